// File: Bender.yml
package:
  name: vaddrgen

sources:
  - include_dirs:
      - .
    files:
      - logic/vinsn_pkg.sv
      - logic/axi_ax_pkg.sv
      - logic/addr_fifo.sv
      - logic/vinsn_decoder.sv
      - logic/burst_splitter.sv
      - logic/vaddrgen_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - test/tb_vaddrgen_top.sv

// File: logic/addr_fifo.sv
// Small circular-buffer FIFO
// Payload type is a parameter, so one block serves the request and command queues
// Head is shown on data_o while the FIFO is not empty

`timescale 1ns/10ps

module addr_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
      // Simultaneous push and pop keep the fill level
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

// File: logic/axi_ax_pkg.sv
// Bus-side types of the vector address generator
// AXI AR/AW beat description and the command queued for the load/store units

`include "mem_addrgen_macros.svh"

package axi_ax_pkg;

  typedef logic [`ADDR_W-1:0] axi_addr_t;
  // Beats per burst minus one
  typedef logic [7:0]         axi_len_t;
  // log2 of the bytes per beat
  typedef logic [2:0]         axi_size_t;
  typedef logic [1:0]         axi_burst_t;

  // Incrementing burst encoding
  localparam axi_burst_t AXI_BURST_INCR = 2'b01;

  ////////////////////
  // AR/AW beat
  ////////////////////

  typedef struct packed {
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  ////////////////////
  // LSU command
  ////////////////////

  // Mirrors the beat so the load/store side can walk the data phase
  typedef struct packed {
    axi_addr_t addr;
    axi_len_t  len;
    axi_size_t size;
    logic      is_load;
  } ls_cmd_t;

endpackage

// File: logic/burst_splitter.sv
// Burst splitter
// Turns one address request into AXI AR or AW beats, one per cycle
// Unit-stride requests become INCR bursts cut at 256 beats and at 4 KiB pages
// Strided requests give one single-beat access per element
// Each accepted beat pushes a matching command for the load/store units

`timescale 1ns/10ps
`include "mem_addrgen_macros.svh"

module burst_splitter import vinsn_pkg::*; import axi_ax_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  addr_req_t req_i,
  input  logic      req_empty_i,
  output logic      req_pop_o,
  output axi_ax_t   ar_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  output axi_ax_t   aw_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  output ls_cmd_t   cmd_o,
  output logic      cmd_push_o,
  input  logic      cmd_full_i,
  input  logic      head_is_load_i
);

  localparam int unsigned AW = `ADDR_W;
  localparam int unsigned SL = `AXI_SIZE_LOG;
  localparam int unsigned PB = `PAGE_BITS;

  // One extra bit so end-of-range sums do not wrap
  typedef logic [AW:0] wide_t;

  localparam wide_t BURST_LAST = wide_t'(`MAX_BURST_BEATS * `AXI_STRB_BYTES - 1);

  logic          busy_q, busy_d;
  addr_req_t     cur_q, cur_d;
  wide_t         bytes_left, req_end, page_end, cap_end, last_byte;
  logic [AW-1:0] span, burst_elems;
  axi_len_t      burst_len;
  axi_ax_t       beat;
  logic          target_ready, order_ok, issue;

  // Last byte touched by a beat, from its own fields
  function automatic wide_t burst_last_byte(axi_ax_t ax);
    wide_t start;
    start = {1'b0, ax.addr[AW-1:SL], {SL{1'b0}}};
    return start + (wide_t'(ax.len) + 1'b1) * `AXI_STRB_BYTES - 1'b1;
  endfunction

  ////////////////////
  // Burst limits
  ////////////////////

  assign bytes_left = wide_t'(cur_q.len) << cur_q.vew;
  assign req_end    = wide_t'(cur_q.addr) + bytes_left - 1'b1;
  assign page_end   = {1'b0, cur_q.addr[AW-1:PB], {PB{1'b1}}};
  assign cap_end    = {1'b0, cur_q.addr[AW-1:SL], {SL{1'b0}}} + BURST_LAST;

  // Smallest of request end, page end and 256-beat cap
  always_comb begin
    last_byte = req_end;
    if (page_end < last_byte) last_byte = page_end;
    if (cap_end < last_byte) last_byte = cap_end;
  end

  // Difference stays below 256 beats, so 8 bits are enough
  assign burst_len   = last_byte[SL +: 8] - cur_q.addr[SL +: 8];
  // Bytes covered from the unaligned start
  assign span        = last_byte[AW-1:0] - cur_q.addr + 1'b1;
  assign burst_elems = span >> cur_q.vew;

  ////////////////////
  // Beat issue
  ////////////////////

  always_comb begin
    beat.addr  = cur_q.addr;
    beat.burst = AXI_BURST_INCR;
    if (cur_q.is_burst) begin
      // Full bus width for every unit-stride beat
      beat.len  = burst_len;
      beat.size = axi_size_t'(SL);
    end else begin
      beat.len  = '0;
      beat.size = axi_size_t'(cur_q.vew);
    end
  end

  assign target_ready = cur_q.is_load ? ar_ready_i : aw_ready_i;
  // Keep loads and stores from overtaking each other in the command queue
  assign order_ok     = (head_is_load_i == cur_q.is_load);
  // Valid only with ready, so every offered beat is taken
  assign issue        = busy_q && target_ready && !cmd_full_i && order_ok;

  assign ar_o       = beat;
  assign aw_o       = beat;
  assign ar_valid_o = issue && cur_q.is_load;
  assign aw_valid_o = issue && !cur_q.is_load;

  assign cmd_o = '{
    addr:    beat.addr,
    len:     beat.len,
    size:    beat.size,
    is_load: cur_q.is_load
  };
  assign cmd_push_o = issue;

  ////////////////////
  // Request walk
  ////////////////////

  always_comb begin
    busy_d    = busy_q;
    cur_d     = cur_q;
    req_pop_o = 1'b0;
    if (!busy_q) begin
      // Take a working copy, the FIFO head stays until the last beat
      if (!req_empty_i) begin
        cur_d  = req_i;
        busy_d = 1'b1;
      end
    end else if (issue) begin
      if (cur_q.is_burst) begin
        cur_d.addr = last_byte[AW-1:0] + 1'b1;
        cur_d.len  = cur_q.len - burst_elems[`VL_W-1:0];
      end else begin
        cur_d.addr = cur_q.addr + cur_q.stride;
        cur_d.len  = cur_q.len - 1'b1;
      end
      // Last beat retires the request
      if (cur_d.len == '0) begin
        busy_d    = 1'b0;
        req_pop_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Working copy of the request
  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

  a_one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o));
  a_no_page_cross: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid_o || aw_valid_o) |->
      ((burst_last_byte(beat) >> PB) == (wide_t'(beat.addr) >> PB)));

endmodule

// File: logic/vaddrgen_top.sv
// Vector memory address generator top level
// Decoder and splitter joined by a request queue
// Beats go out on AR/AW, matching commands wait in a queue for the load/store units

`timescale 1ns/10ps
`include "mem_addrgen_macros.svh"

module vaddrgen_top import vinsn_pkg::*; import axi_ax_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction side
  input  mem_insn_t insn_i,
  input  logic      insn_valid_i,
  output logic      insn_ready_o,
  output logic      insn_ack_o,
  output addr_exc_t exc_o,
  // AXI address channels
  output axi_ax_t   ar_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  output axi_ax_t   aw_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  // Load/store unit commands
  output ls_cmd_t   cmd_o,
  output logic      cmd_valid_o,
  input  logic      cmd_pop_i
);

  addr_req_t req_in, req_head;
  logic      req_push, req_pop, req_full, req_empty;
  ls_cmd_t   cmd_in;
  logic      cmd_push, cmd_full, cmd_empty;
  logic      head_is_load;

  vinsn_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .insn_ack_o   (insn_ack_o),
    .exc_o        (exc_o),
    .req_o        (req_in),
    .req_push_o   (req_push),
    .req_full_i   (req_full)
  );

  addr_fifo #(
    .DEPTH     (`REQ_Q_DEPTH),
    .payload_t (addr_req_t)
  ) u_req_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_push),
    .data_i  (req_in),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  // With no command queued, the request in progress sets the direction
  assign head_is_load = cmd_empty ? req_head.is_load : cmd_o.is_load;

  burst_splitter u_splitter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_head),
    .req_empty_i    (req_empty),
    .req_pop_o      (req_pop),
    .ar_o           (ar_o),
    .ar_valid_o     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .aw_o           (aw_o),
    .aw_valid_o     (aw_valid_o),
    .aw_ready_i     (aw_ready_i),
    .cmd_o          (cmd_in),
    .cmd_push_o     (cmd_push),
    .cmd_full_i     (cmd_full),
    .head_is_load_i (head_is_load)
  );

  addr_fifo #(
    .DEPTH     (`CMD_Q_DEPTH),
    .payload_t (ls_cmd_t)
  ) u_cmd_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_push),
    .data_i  (cmd_in),
    .pop_i   (cmd_pop_i),
    .data_o  (cmd_o),
    .full_o  (cmd_full),
    .empty_o (cmd_empty)
  );

  assign cmd_valid_o = !cmd_empty;

endmodule

// File: logic/vinsn_decoder.sv
// Vector memory instruction decoder
// Takes one instruction at a time and checks the base against the element width
// Misaligned bases raise an exception, aligned ones become an address request
// The instruction is acknowledged one cycle after it is taken

`timescale 1ns/10ps

module vinsn_decoder import vinsn_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  mem_insn_t insn_i,
  input  logic      insn_valid_i,
  output logic      insn_ready_o,
  output logic      insn_ack_o,
  output addr_exc_t exc_o,
  output addr_req_t req_o,
  output logic      req_push_o,
  input  logic      req_full_i
);

  typedef enum logic {
    DEC_IDLE,
    DEC_CHECK
  } dec_state_e;

  dec_state_e state_q, state_d;
  mem_insn_t  insn_q;
  logic       accept;
  logic [2:0] align_mask;
  logic       misaligned;

  // Accept only when a request slot is free
  assign insn_ready_o = (state_q == DEC_IDLE) && !req_full_i;
  assign accept       = insn_valid_i && insn_ready_o;

  // Low address bits that must be zero for each element width
  always_comb begin
    case (insn_q.vew)
      EW8:     align_mask = 3'b000;
      EW16:    align_mask = 3'b001;
      EW32:    align_mask = 3'b011;
      default: align_mask = 3'b111;
    endcase
  end

  assign misaligned = |(insn_q.addr[2:0] & align_mask);

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_IDLE:  if (accept) state_d = DEC_CHECK;
      default:   state_d = DEC_IDLE;
    endcase
  end

  // Ack in the check cycle, whichever way the check goes
  assign insn_ack_o = (state_q == DEC_CHECK);

  assign exc_o.valid   = insn_ack_o && misaligned;
  assign exc_o.cause   = exc_o.valid ? EXC_MISALIGNED : EXC_NONE;
  assign exc_o.is_load = exc_o.valid && insn_q.is_load;

  // No traffic at all for a faulting instruction
  assign req_push_o = insn_ack_o && !misaligned;

  assign req_o = '{
    addr:     insn_q.addr,
    len:      insn_q.vl,
    stride:   insn_q.stride,
    vew:      insn_q.vew,
    is_load:  insn_q.is_load,
    is_burst: insn_q.is_unit_stride
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DEC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction capture
  always_ff @(posedge clk_i) begin
    if (accept) insn_q <= insn_i;
  end

endmodule

// File: logic/vinsn_pkg.sv
// Instruction-side types of the vector address generator
// Incoming memory instruction, internal address request and exception report

`include "mem_addrgen_macros.svh"

package vinsn_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`VL_W-1:0]   vlen_t;

  // Element width as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Only misalignment is reported here
  typedef enum logic [1:0] {
    EXC_NONE       = 2'd0,
    EXC_MISALIGNED = 2'd1
  } exc_cause_e;

  // Vector load or store as issued to the unit
  typedef struct packed {
    addr_t addr;
    vlen_t vl;
    addr_t stride;
    vew_e  vew;
    logic  is_load;
    logic  is_unit_stride;
  } mem_insn_t;

  // Request from the decoder to the splitter
  typedef struct packed {
    addr_t addr;
    vlen_t len;
    addr_t stride;
    vew_e  vew;
    logic  is_load;
    // Unit-stride requests become INCR bursts
    logic  is_burst;
  } addr_req_t;

  typedef struct packed {
    logic       valid;
    exc_cause_e cause;
    logic       is_load;
  } addr_exc_t;

endpackage

// File: mem_addrgen_macros.svh
// Vector memory address generator
// Shared widths, bus geometry and queue depths used by the packages and the RTL

`ifndef MEM_ADDRGEN_MACROS_SVH
`define MEM_ADDRGEN_MACROS_SVH

// Byte address width
`define ADDR_W 32
// Element count width
`define VL_W 16

// Data bus is 64 bits wide
`define AXI_STRB_BYTES 8
`define AXI_SIZE_LOG 3

// 4 KiB pages, AXI bursts may not cross them
`define PAGE_BITS 12
// INCR bursts are limited to 256 beats
`define MAX_BURST_BEATS 256

// Two requests in flight, four commands buffered
`define REQ_Q_DEPTH 2
`define CMD_Q_DEPTH 4

`endif

// File: test/tb_vaddrgen_top.sv
// Testbench for the vector memory address generator
// Random loads and stores with random AXI ready and command pops
// A queue model predicts every AR/AW beat and every load/store command

`timescale 1ns/10ps
`include "mem_addrgen_macros.svh"

module tb_vaddrgen_top import vinsn_pkg::*; import axi_ax_pkg::*; ();

  localparam int unsigned NUM_INSN    = 40;
  localparam int unsigned ACCEPT_WAIT = 5000;
  localparam int unsigned DRAIN_WAIT  = 20000;

  logic      clk_i;
  logic      rst_ni;
  mem_insn_t insn_i;
  logic      insn_valid_i, insn_ready_o, insn_ack_o;
  addr_exc_t exc_o;
  axi_ax_t   ar_o, aw_o;
  logic      ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  ls_cmd_t   cmd_o;
  logic      cmd_valid_o, cmd_pop_i;

  integer    seed = 32'h7f7d0703;
  mem_insn_t insns [NUM_INSN];
  int unsigned gaps [NUM_INSN];

  // Model state
  axi_ax_t     exp_beats [$];
  logic        exp_dirs [$];
  ls_cmd_t     cmd_model [$];
  logic        ack_due = 1'b0;
  logic        exc_due = 1'b0;
  logic        exc_dir_due = 1'b0;

  vaddrgen_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////
  // Failure handling
  ////////////////////

  task automatic end_in_failure();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    end_in_failure();
  endtask

  task automatic raise_error(string msg);
    $display("ERROR %s", msg);
    end_in_failure();
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Base must be a multiple of the element size
  function automatic logic is_misaligned(mem_insn_t insn);
    return (insn.addr & ((32'd1 << insn.vew) - 1)) != 0;
  endfunction

  // Expected beats of one aligned instruction, in issue order
  task automatic expand_insn(mem_insn_t insn);
    longint unsigned a, n, w, last, start, page_last, cap_last;
    axi_ax_t bt;
    a = insn.addr;
    n = insn.vl;
    w = insn.vew;
    while (n != 0) begin
      bt.burst = AXI_BURST_INCR;
      if (insn.is_unit_stride) begin
        start     = a & 64'hFFFF_FFFF_FFFF_FFF8;
        last      = a + (n << w) - 1;
        page_last = a | ((64'd1 << `PAGE_BITS) - 1);
        cap_last  = start + `MAX_BURST_BEATS * `AXI_STRB_BYTES - 1;
        if (page_last < last) last = page_last;
        if (cap_last < last) last = cap_last;
        bt.addr = 32'(a);
        bt.len  = 8'(((last & 64'hFFFF_FFFF_FFFF_FFF8) - start) >> 3);
        bt.size = 3'(`AXI_SIZE_LOG);
        n = n - ((last - a + 1) >> w);
        a = (last + 1) & 64'hFFFF_FFFF;
      end else begin
        // One element per beat
        bt.addr = 32'(a);
        bt.len  = '0;
        bt.size = 3'(w);
        a = (a + insn.stride) & 64'hFFFF_FFFF;
        n = n - 1;
      end
      exp_beats.push_back(bt);
      exp_dirs.push_back(insn.is_load);
    end
  endtask

  ////////////////////
  // Stimulus set
  ////////////////////

  task automatic build_stimulus();
    int unsigned kind;
    mem_insn_t   in;
    for (int i = 0; i < NUM_INSN; i++) begin
      kind              = $unsigned($random(seed)) % 5;
      in.vew            = vew_e'($random(seed) & 3);
      in.is_load        = $random(seed) & 1;
      in.is_unit_stride = 1'b1;
      in.stride         = '0;
      in.addr = ($random(seed) & 32'h0FFF_FFFF) & ~((32'd1 << in.vew) - 1);
      in.vl   = 16'(1 + $unsigned($random(seed)) % 64);
      case (kind)
        0: begin
          // Misaligned base, needs at least 16-bit elements
          if (in.vew == EW8) in.vew = EW16;
          in.addr = in.addr | 32'd1;
        end
        // Long bursts reach the 256-beat cap for wide elements
        1: in.vl = 16'(300 + $unsigned($random(seed)) % 500);
        2: begin
          // Start in the last 256 bytes of a page
          in.addr = (in.addr & 32'hFFFF_F000) | 32'h0000_0F00 | ($random(seed) & 32'h0F8);
          in.vl   = 16'(32 + $unsigned($random(seed)) % 200);
        end
        3: begin
          in.is_unit_stride = 1'b0;
          in.vl     = 16'(1 + $unsigned($random(seed)) % 8);
          in.stride = ($random(seed) & 32'h3FF) << in.vew;
        end
        default: ;
      endcase
      insns[i] = in;
      gaps[i]  = $unsigned($random(seed)) % 4;
    end
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  // Samples pre-edge values, then drives ready and pop for the next cycle
  always @(posedge clk_i) begin : monitor
    axi_ax_t exp_beat;
    logic    exp_load;
    ls_cmd_t exp_cmd;
    if (rst_ni) begin
      assert (insn_ack_o == ack_due) else mismatch("insn ack", ack_due, insn_ack_o);
      assert (exc_o.valid == exc_due) else mismatch("exception valid", exc_due, exc_o.valid);
      if (exc_due) begin
        assert (exc_o.is_load == exc_dir_due)
          else mismatch("exception direction", exc_dir_due, exc_o.is_load);
        assert (exc_o.cause == EXC_MISALIGNED)
          else mismatch("exception cause", EXC_MISALIGNED, exc_o.cause);
      end
      // Ack is due one cycle after acceptance
      ack_due = insn_valid_i && insn_ready_o;
      exc_due = 1'b0;
      if (ack_due) begin
        if (is_misaligned(insn_i)) begin
          exc_due     = 1'b1;
          exc_dir_due = insn_i.is_load;
        end else begin
          expand_insn(insn_i);
        end
      end
      if (cmd_pop_i) begin
        assert (cmd_valid_o) else raise_error("command popped while the queue was empty");
        exp_cmd = cmd_model.pop_front();
        assert (cmd_o == exp_cmd) else mismatch("command", exp_cmd, cmd_o);
      end
      assert (!(ar_valid_o && aw_valid_o)) else raise_error("AR and AW valid together");
      if (ar_valid_o || aw_valid_o) begin
        assert ((ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i))
          else raise_error("address valid raised without ready");
        assert (exp_beats.size() > 0) else raise_error("AXI beat issued with none expected");
        exp_beat = exp_beats.pop_front();
        exp_load = exp_dirs.pop_front();
        assert (ar_valid_o == exp_load) else mismatch("beat direction", exp_load, ar_valid_o);
        if (ar_valid_o) begin
          assert (ar_o == exp_beat) else mismatch("AR beat", exp_beat, ar_o);
        end else begin
          assert (aw_o == exp_beat) else mismatch("AW beat", exp_beat, aw_o);
        end
        cmd_model.push_back('{addr: exp_beat.addr, len: exp_beat.len,
                              size: exp_beat.size, is_load: exp_load});
      end
      ar_ready_i <= ($random(seed) & 3) != 0;
      aw_ready_i <= ($random(seed) & 3) != 0;
      // Pop only what the model says is queued after this edge
      cmd_pop_i  <= (cmd_model.size() != 0) && (($random(seed) & 1) != 0);
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int unsigned waited;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    ar_ready_i   = 1'b0;
    aw_ready_i   = 1'b0;
    cmd_pop_i    = 1'b0;
    build_stimulus();

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // Idle state right after reset
    assert (insn_ready_o) else mismatch("reset ready", 1, insn_ready_o);
    assert (!ar_valid_o && !aw_valid_o) else raise_error("address valid high after reset");
    assert (!cmd_valid_o) else mismatch("reset cmd valid", 0, cmd_valid_o);
    assert (!insn_ack_o && !exc_o.valid) else raise_error("ack or exception after reset");

    for (int i = 0; i < NUM_INSN; i++) begin
      insn_i       <= insns[i];
      insn_valid_i <= 1'b1;
      waited = 0;
      forever begin
        @(posedge clk_i);
        if (insn_ready_o) break;
        waited++;
        if (waited > ACCEPT_WAIT) raise_error("timeout waiting for instruction acceptance");
      end
      insn_valid_i <= 1'b0;
      repeat (gaps[i]) @(posedge clk_i);
    end

    // Let the last beats and commands drain
    waited = 0;
    forever begin
      @(negedge clk_i);
      if (exp_beats.size() == 0 && cmd_model.size() == 0 && !ack_due) break;
      waited++;
      if (waited > DRAIN_WAIT) raise_error("timeout waiting for beats and commands to drain");
    end

    // Nothing may remain in flight once the model is drained
    if (insn_ready_o && !cmd_valid_o && !ar_valid_o && !aw_valid_o) begin
      $display("TEST PASS");
      $finish;
    end else begin
      raise_error("DUT still busy after the last expected command");
    end
  end

endmodule

// File: vaddrgen_top.f
+incdir+.
logic/vinsn_pkg.sv
logic/axi_ax_pkg.sv
logic/addr_fifo.sv
logic/vinsn_decoder.sv
logic/burst_splitter.sv
logic/vaddrgen_top.sv
test/tb_vaddrgen_top.sv
